//--- switch_pkg.sv
package switch_pkg;

   // ----------------------------------------
   // Datapath widths
   // ----------------------------------------
   localparam int data_width = 64;
   localparam int ctrl_width = 8;
   localparam int num_ports  = 4;
   localparam int port_bits  = 2;
   localparam int mac_width  = 48;

   // ----------------------------------------
   // Storage depths
   // ----------------------------------------
   localparam int table_entries  = 8;
   localparam int table_bits     = 3;
   localparam int buffer_depth   = 32;
   localparam int buffer_bits    = 5;
   localparam int decision_depth = 4;

   // One 64-bit header word read as packet word 0 or word 1
   typedef union packed {
      // Word 0
      struct packed {
         logic [mac_width-1:0] dst_mac;
         logic [15:0]          src_hi;
      } hdr0;
      // Word 1 carries an ethertype the switch ignores
      struct packed {
         logic [31:0] src_lo;
         logic [15:0] ethertype;
         logic [15:0] unused;
      } hdr1;
   } hdr_word_t;

endpackage

//--- input_arbiter.sv
`timescale 1ns/1ps

module input_arbiter (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [switch_pkg::data_width-1:0]   in_data_0,
   input  logic [switch_pkg::ctrl_width-1:0]   in_ctrl_0,
   input  logic                                in_wr_0,
   output logic                                in_rdy_0,
   input  logic [switch_pkg::data_width-1:0]   in_data_1,
   input  logic [switch_pkg::ctrl_width-1:0]   in_ctrl_1,
   input  logic                                in_wr_1,
   output logic                                in_rdy_1,
   input  logic [switch_pkg::data_width-1:0]   in_data_2,
   input  logic [switch_pkg::ctrl_width-1:0]   in_ctrl_2,
   input  logic                                in_wr_2,
   output logic                                in_rdy_2,
   input  logic [switch_pkg::data_width-1:0]   in_data_3,
   input  logic [switch_pkg::ctrl_width-1:0]   in_ctrl_3,
   input  logic                                in_wr_3,
   output logic                                in_rdy_3,
   input  logic                                buf_rdy,
   input  logic                                lut_rdy,
   output logic                                arb_wr,
   output logic [switch_pkg::data_width-1:0]   arb_data,
   output logic [switch_pkg::ctrl_width-1:0]   arb_ctrl,
   output logic [switch_pkg::port_bits-1:0]    arb_port
);

   logic [switch_pkg::data_width-1:0] data_sel [switch_pkg::num_ports];
   logic [switch_pkg::ctrl_width-1:0] ctrl_sel [switch_pkg::num_ports];
   logic [switch_pkg::num_ports-1:0]  req;
   logic [switch_pkg::num_ports-1:0]  rdy_vec;
   logic [switch_pkg::port_bits-1:0]  grant;
   logic [switch_pkg::port_bits-1:0]  cand;
   logic [switch_pkg::port_bits-1:0]  next_grant;
   logic                              found;
   logic                              in_pkt;
   logic                              xfer;

   assign data_sel[0] = in_data_0;
   assign data_sel[1] = in_data_1;
   assign data_sel[2] = in_data_2;
   assign data_sel[3] = in_data_3;
   assign ctrl_sel[0] = in_ctrl_0;
   assign ctrl_sel[1] = in_ctrl_1;
   assign ctrl_sel[2] = in_ctrl_2;
   assign ctrl_sel[3] = in_ctrl_3;
   assign req         = {in_wr_3, in_wr_2, in_wr_1, in_wr_0};

   // Search upward from the port after the last grant, wrapping round to it
   always_comb begin
      next_grant = grant;
      found      = 1'b0;
      cand       = grant;
      for (int i = 1; i <= switch_pkg::num_ports; i++) begin
         cand = grant + (switch_pkg::port_bits)'(i);
         if (!found && req[cand]) begin
            next_grant = cand;
            found      = 1'b1;
         end
      end
   end

   // Grant is held from the first word to the last
   always_ff @(posedge clk) begin
      if (reset) begin
         grant  <= '0;
         in_pkt <= 1'b0;
      end else if (!in_pkt) begin
         if (found) begin
            grant  <= next_grant;
            in_pkt <= 1'b1;
         end
      end else if (xfer && arb_ctrl != '0) begin
         in_pkt <= 1'b0;
      end
   end

   assign arb_wr   = in_pkt && req[grant];
   assign arb_data = data_sel[grant];
   assign arb_ctrl = ctrl_sel[grant];
   assign arb_port = grant;
   assign xfer     = arb_wr && buf_rdy && lut_rdy;

   always_comb begin
      rdy_vec        = '0;
      rdy_vec[grant] = in_pkt && buf_rdy && lut_rdy;
   end

   assign in_rdy_0 = rdy_vec[0];
   assign in_rdy_1 = rdy_vec[1];
   assign in_rdy_2 = rdy_vec[2];
   assign in_rdy_3 = rdy_vec[3];

endmodule

//--- packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [switch_pkg::data_width-1:0] arb_data,
   input  logic [switch_pkg::ctrl_width-1:0] arb_ctrl,
   input  logic                              arb_wr,
   input  logic                              lut_rdy,
   input  logic                              buf_rd,
   output logic                              buf_rdy,
   output logic                              buf_wr,
   output logic [switch_pkg::data_width-1:0] buf_data,
   output logic [switch_pkg::ctrl_width-1:0] buf_ctrl
);

   logic [switch_pkg::ctrl_width+switch_pkg::data_width-1:0] mem [switch_pkg::buffer_depth];
   logic [switch_pkg::buffer_bits-1:0] wr_ptr;
   logic [switch_pkg::buffer_bits-1:0] rd_ptr;
   logic [switch_pkg::buffer_bits:0]   count;
   logic                               push;
   logic                               pop;

   // Push only when the lookup takes the same word
   assign push = arb_wr && buf_rdy && lut_rdy;
   assign pop  = buf_rd && buf_wr;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {arb_ctrl, arb_data};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + (switch_pkg::buffer_bits)'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + (switch_pkg::buffer_bits)'(1);
         end
         case ({push, pop})
            2'b10:   count <= count + (switch_pkg::buffer_bits + 1)'(1);
            2'b01:   count <= count - (switch_pkg::buffer_bits + 1)'(1);
            default: count <= count;
         endcase
      end
   end

   assign buf_rdy              = count != (switch_pkg::buffer_bits + 1)'(switch_pkg::buffer_depth);
   assign buf_wr               = count != '0;
   assign {buf_ctrl, buf_data} = mem[rd_ptr];

endmodule

//--- mac_lookup.sv
`timescale 1ns/1ps

module mac_lookup (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [switch_pkg::data_width-1:0] arb_data,
   input  logic [switch_pkg::port_bits-1:0]  arb_port,
   input  logic                              arb_wr,
   input  logic [switch_pkg::ctrl_width-1:0] arb_ctrl,
   input  logic                              buf_rdy,
   input  logic                              dec_rd,
   output logic                              lut_rdy,
   output logic                              dec_wr,
   output logic [switch_pkg::num_ports-1:0]  dec_mask
);

   switch_pkg::hdr_word_t              hdr;
   logic                               xfer;
   logic [1:0]                         word_pos;
   logic                               lookup_pend;
   logic [switch_pkg::mac_width-1:0]   dst_mac;
   logic [15:0]                        src_hi;
   logic [31:0]                        src_lo;
   logic [switch_pkg::mac_width-1:0]   src_mac;
   logic [switch_pkg::port_bits-1:0]   src_port;

   logic [switch_pkg::table_entries-1:0] tbl_valid;
   logic [switch_pkg::mac_width-1:0]     tbl_mac [switch_pkg::table_entries];
   logic [switch_pkg::port_bits-1:0]     tbl_port [switch_pkg::table_entries];
   logic [switch_pkg::table_bits-1:0]    rr_ptr;
   logic                                 dst_hit;
   logic [switch_pkg::port_bits-1:0]     dst_port;
   logic                                 src_hit;
   logic [switch_pkg::table_bits-1:0]    src_idx;
   logic [switch_pkg::num_ports-1:0]     mask;

   logic [switch_pkg::num_ports-1:0]                 dec_mem [switch_pkg::decision_depth];
   logic [$clog2(switch_pkg::decision_depth)-1:0]    dec_wr_ptr;
   logic [$clog2(switch_pkg::decision_depth)-1:0]    dec_rd_ptr;
   logic [$clog2(switch_pkg::decision_depth+1)-1:0]  dec_count;
   logic                                             dec_pop;

   assign hdr     = arb_data;
   assign xfer    = arb_wr && buf_rdy && lut_rdy;
   assign src_mac = {src_hi, src_lo};

   // ----------------------------------------
   // Header capture
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         word_pos    <= 2'd0;
         lookup_pend <= 1'b0;
      end else begin
         lookup_pend <= xfer && word_pos == 2'd1;
         if (xfer) begin
            if (arb_ctrl != '0) begin
               word_pos <= 2'd0;
            end else if (word_pos != 2'd2) begin
               word_pos <= word_pos + 2'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (xfer && word_pos == 2'd0) begin
         dst_mac <= hdr.hdr0.dst_mac;
         src_hi  <= hdr.hdr0.src_hi;
      end
      if (xfer && word_pos == 2'd1) begin
         src_lo   <= hdr.hdr1.src_lo;
         src_port <= arb_port;
      end
   end

   // ----------------------------------------
   // Table search and learning
   // ----------------------------------------
   always_comb begin
      dst_hit  = 1'b0;
      dst_port = '0;
      src_hit  = 1'b0;
      src_idx  = '0;
      for (int i = 0; i < switch_pkg::table_entries; i++) begin
         if (tbl_valid[i] && tbl_mac[i] == dst_mac) begin
            dst_hit  = 1'b1;
            dst_port = tbl_port[i];
         end
         if (tbl_valid[i] && tbl_mac[i] == src_mac) begin
            src_hit = 1'b1;
            src_idx = (switch_pkg::table_bits)'(i);
         end
      end
   end

   // Flood on miss, filter when the destination sits on the arrival port
   always_comb begin
      if (!dst_hit) begin
         mask = ~((switch_pkg::num_ports)'(1) << src_port);
      end else if (dst_port == src_port) begin
         mask = '0;
      end else begin
         mask = (switch_pkg::num_ports)'(1) << dst_port;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tbl_valid <= '0;
         rr_ptr    <= '0;
      end else if (lookup_pend && !src_hit) begin
         tbl_valid[rr_ptr] <= 1'b1;
         rr_ptr            <= rr_ptr + (switch_pkg::table_bits)'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (lookup_pend) begin
         if (src_hit) begin
            tbl_port[src_idx] <= src_port;
         end else begin
            tbl_mac[rr_ptr]  <= src_mac;
            tbl_port[rr_ptr] <= src_port;
         end
      end
   end

   // ----------------------------------------
   // Decision FIFO
   // ----------------------------------------
   assign dec_pop = dec_rd && dec_wr;

   always_ff @(posedge clk) begin
      if (lookup_pend) begin
         dec_mem[dec_wr_ptr] <= mask;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dec_wr_ptr <= '0;
         dec_rd_ptr <= '0;
         dec_count  <= '0;
      end else begin
         if (lookup_pend) begin
            dec_wr_ptr <= dec_wr_ptr + 1'b1;
         end
         if (dec_pop) begin
            dec_rd_ptr <= dec_rd_ptr + 1'b1;
         end
         if (lookup_pend && !dec_pop) begin
            dec_count <= dec_count + 1'b1;
         end else if (!lookup_pend && dec_pop) begin
            dec_count <= dec_count - 1'b1;
         end
      end
   end

   assign lut_rdy  = dec_count != ($clog2(switch_pkg::decision_depth+1))'(switch_pkg::decision_depth);
   assign dec_wr   = dec_count != '0;
   assign dec_mask = dec_mem[dec_rd_ptr];

endmodule

//--- egress_demux.sv
`timescale 1ns/1ps

module egress_demux (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [switch_pkg::data_width-1:0] buf_data,
   input  logic [switch_pkg::ctrl_width-1:0] buf_ctrl,
   input  logic                              buf_wr,
   input  logic [switch_pkg::num_ports-1:0]  dec_mask,
   input  logic                              dec_wr,
   input  logic                              out_rdy_0,
   input  logic                              out_rdy_1,
   input  logic                              out_rdy_2,
   input  logic                              out_rdy_3,
   output logic                              buf_rd,
   output logic                              dec_rd,
   output logic [switch_pkg::data_width-1:0] out_data_0,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_0,
   output logic                              out_wr_0,
   output logic [switch_pkg::data_width-1:0] out_data_1,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_1,
   output logic                              out_wr_1,
   output logic [switch_pkg::data_width-1:0] out_data_2,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_2,
   output logic                              out_wr_2,
   output logic [switch_pkg::data_width-1:0] out_data_3,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_3,
   output logic                              out_wr_3
);

   logic                             busy;
   logic [switch_pkg::num_ports-1:0] mask_q;
   logic [switch_pkg::num_ports-1:0] rdy_vec;
   logic                             all_rdy;
   logic                             fire;
   logic                             last;

   assign rdy_vec = {out_rdy_3, out_rdy_2, out_rdy_1, out_rdy_0};

   // Unselected ports never hold a word back; an empty mask always drains
   assign all_rdy = &(rdy_vec | ~mask_q);
   assign fire    = busy && buf_wr && all_rdy;
   assign last    = buf_ctrl != '0;
   assign buf_rd  = fire;
   assign dec_rd  = fire && last;

   // Start a packet once both its first word and its decision are present
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (!busy) begin
         if (buf_wr && dec_wr) begin
            busy <= 1'b1;
         end
      end else if (fire && last) begin
         busy <= 1'b0;
      end
   end

   // Mask held for the whole packet
   always_ff @(posedge clk) begin
      if (!busy && buf_wr && dec_wr) begin
         mask_q <= dec_mask;
      end
   end

   // ----------------------------------------
   // Output ports
   // ----------------------------------------
   assign out_data_0 = buf_data;
   assign out_ctrl_0 = buf_ctrl;
   assign out_wr_0   = fire && mask_q[0];
   assign out_data_1 = buf_data;
   assign out_ctrl_1 = buf_ctrl;
   assign out_wr_1   = fire && mask_q[1];
   assign out_data_2 = buf_data;
   assign out_ctrl_2 = buf_ctrl;
   assign out_wr_2   = fire && mask_q[2];
   assign out_data_3 = buf_data;
   assign out_ctrl_3 = buf_ctrl;
   assign out_wr_3   = fire && mask_q[3];

endmodule

//--- sdn_switch.sv
`timescale 1ns/1ps

module sdn_switch (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [switch_pkg::data_width-1:0] in_data_0,
   input  logic [switch_pkg::ctrl_width-1:0] in_ctrl_0,
   input  logic                              in_wr_0,
   output logic                              in_rdy_0,
   input  logic [switch_pkg::data_width-1:0] in_data_1,
   input  logic [switch_pkg::ctrl_width-1:0] in_ctrl_1,
   input  logic                              in_wr_1,
   output logic                              in_rdy_1,
   input  logic [switch_pkg::data_width-1:0] in_data_2,
   input  logic [switch_pkg::ctrl_width-1:0] in_ctrl_2,
   input  logic                              in_wr_2,
   output logic                              in_rdy_2,
   input  logic [switch_pkg::data_width-1:0] in_data_3,
   input  logic [switch_pkg::ctrl_width-1:0] in_ctrl_3,
   input  logic                              in_wr_3,
   output logic                              in_rdy_3,
   output logic [switch_pkg::data_width-1:0] out_data_0,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_0,
   output logic                              out_wr_0,
   input  logic                              out_rdy_0,
   output logic [switch_pkg::data_width-1:0] out_data_1,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_1,
   output logic                              out_wr_1,
   input  logic                              out_rdy_1,
   output logic [switch_pkg::data_width-1:0] out_data_2,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_2,
   output logic                              out_wr_2,
   input  logic                              out_rdy_2,
   output logic [switch_pkg::data_width-1:0] out_data_3,
   output logic [switch_pkg::ctrl_width-1:0] out_ctrl_3,
   output logic                              out_wr_3,
   input  logic                              out_rdy_3
);

   // Arbiter stream, shared by buffer and lookup
   logic [switch_pkg::data_width-1:0] arb_data;
   logic [switch_pkg::ctrl_width-1:0] arb_ctrl;
   logic [switch_pkg::port_bits-1:0]  arb_port;
   logic                              arb_wr;
   logic                              buf_rdy;
   logic                              lut_rdy;

   // Buffer head
   logic [switch_pkg::data_width-1:0] buf_data;
   logic [switch_pkg::ctrl_width-1:0] buf_ctrl;
   logic                              buf_wr;
   logic                              buf_rd;

   // Forwarding decisions
   logic [switch_pkg::num_ports-1:0]  dec_mask;
   logic                              dec_wr;
   logic                              dec_rd;

   // ----------------------------------------
   // Datapath blocks
   // ----------------------------------------
   input_arbiter u_input_arbiter (.*);
   packet_buffer u_packet_buffer (.*);
   mac_lookup    u_mac_lookup    (.*);
   egress_demux  u_egress_demux  (.*);

endmodule

//--- tb_sdn_switch.sv
`timescale 1ns/1ps

module tb_sdn_switch;

   // One queue entry is a ctrl word on top of a data word
   typedef logic [switch_pkg::ctrl_width+switch_pkg::data_width-1:0] word_q_t [$];

   // 20 packets of 4 words over all tests
   localparam int total_words     = 80;
   localparam int watchdog_cycles = total_words * 20 + 600;
   localparam int wait_limit      = 400;

   localparam logic [47:0] mac_a     = 48'h0200_0000_000a;
   localparam logic [47:0] mac_b     = 48'h0200_0000_000b;
   localparam logic [47:0] mac_c     = 48'h0200_0000_000c;
   localparam logic [47:0] mac_far   = 48'h02ff_ffff_fff0;
   localparam logic [47:0] mac_far2  = 48'h02ff_ffff_fff1;
   localparam logic [47:0] mac_quad  = 48'h0200_0000_0100;
   localparam logic [47:0] mac_new   = 48'h0200_0000_0200;
   localparam logic [47:0] mac_probe = 48'h0200_0000_0300;

   logic                              clk;
   logic                              reset;
   logic [switch_pkg::data_width-1:0] in_data [switch_pkg::num_ports];
   logic [switch_pkg::ctrl_width-1:0] in_ctrl [switch_pkg::num_ports];
   logic [switch_pkg::num_ports-1:0]  in_wr;
   logic [switch_pkg::num_ports-1:0]  in_rdy;
   logic [switch_pkg::data_width-1:0] out_data [switch_pkg::num_ports];
   logic [switch_pkg::ctrl_width-1:0] out_ctrl [switch_pkg::num_ports];
   logic [switch_pkg::num_ports-1:0]  out_wr;
   logic [switch_pkg::num_ports-1:0]  out_rdy;

   word_q_t     got_q [switch_pkg::num_ports];
   word_q_t     exp_q [switch_pkg::num_ports];
   logic [31:0] lfsr_state = 32'h645;
   int          checks     = 0;
   int          mismatches = 0;
   int          failures   = 0;

   sdn_switch uut (
      .clk(clk), .reset(reset),
      .in_data_0(in_data[0]), .in_ctrl_0(in_ctrl[0]), .in_wr_0(in_wr[0]), .in_rdy_0(in_rdy[0]),
      .in_data_1(in_data[1]), .in_ctrl_1(in_ctrl[1]), .in_wr_1(in_wr[1]), .in_rdy_1(in_rdy[1]),
      .in_data_2(in_data[2]), .in_ctrl_2(in_ctrl[2]), .in_wr_2(in_wr[2]), .in_rdy_2(in_rdy[2]),
      .in_data_3(in_data[3]), .in_ctrl_3(in_ctrl[3]), .in_wr_3(in_wr[3]), .in_rdy_3(in_rdy[3]),
      .out_data_0(out_data[0]), .out_ctrl_0(out_ctrl[0]),
      .out_wr_0(out_wr[0]), .out_rdy_0(out_rdy[0]),
      .out_data_1(out_data[1]), .out_ctrl_1(out_ctrl[1]),
      .out_wr_1(out_wr[1]), .out_rdy_1(out_rdy[1]),
      .out_data_2(out_data[2]), .out_ctrl_2(out_ctrl[2]),
      .out_wr_2(out_wr[2]), .out_rdy_2(out_rdy[2]),
      .out_data_3(out_data[3]), .out_ctrl_3(out_ctrl[3]),
      .out_wr_3(out_wr[3]), .out_rdy_3(out_rdy[3])
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Output words are stable at the falling edge
   always @(negedge clk) begin
      for (int p = 0; p < switch_pkg::num_ports; p++) begin
         if (out_wr[p]) begin
            got_q[p].push_back({out_ctrl[p], out_data[p]});
         end
      end
   end

   // ----------------------------------------
   // Stimulus helpers
   // ----------------------------------------
   // Taps 32, 22, 2, 1
   function automatic logic lfsr_step();
      logic fb;
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] rand_word();
      logic [63:0] w;
      w = '0;
      for (int i = 0; i < 64; i++) begin
         w = {w[62:0], lfsr_step()};
      end
      return w;
   endfunction

   // Two header words and two payload words with ctrl set on the last
   function automatic word_q_t make_packet(input logic [47:0] dst, input logic [47:0] src);
      switch_pkg::hdr_word_t h;
      word_q_t               pkt;
      h.hdr0.dst_mac = dst;
      h.hdr0.src_hi  = src[47:32];
      pkt.push_back({8'h00, h});
      h.hdr1.src_lo    = src[31:0];
      h.hdr1.ethertype = 16'h0800;
      h.hdr1.unused    = '0;
      pkt.push_back({8'h00, h});
      pkt.push_back({8'h00, rand_word()});
      pkt.push_back({8'h01, rand_word()});
      return pkt;
   endfunction

   task automatic send_packet(input int port, input word_q_t pkt);
      logic accepted;
      @(posedge clk);
      #2;
      for (int i = 0; i < pkt.size(); i++) begin
         in_data[port] = pkt[i][switch_pkg::data_width-1:0];
         in_ctrl[port] = pkt[i][switch_pkg::ctrl_width+switch_pkg::data_width-1:switch_pkg::data_width];
         in_wr[port]   = 1'b1;
         accepted      = 1'b0;
         while (!accepted) begin
            @(negedge clk);
            accepted = in_rdy[port];
            @(posedge clk);
            #2;
         end
      end
      in_wr[port] = 1'b0;
   endtask

   task automatic add_expected(input logic [switch_pkg::num_ports-1:0] mask, input word_q_t pkt);
      for (int p = 0; p < switch_pkg::num_ports; p++) begin
         if (mask[p]) begin
            foreach (pkt[i]) exp_q[p].push_back(pkt[i]);
         end
      end
   endtask

   // ----------------------------------------
   // Response checking
   // ----------------------------------------
   task automatic wait_and_check(input string name);
      int   cycles;
      int   n;
      logic done;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < wait_limit) begin
         @(posedge clk);
         cycles++;
         done = 1'b1;
         for (int p = 0; p < switch_pkg::num_ports; p++) begin
            if (got_q[p].size() < exp_q[p].size()) done = 1'b0;
         end
      end
      assert (done) else begin
         failures++;
         $display("%s: output words did not arrive within %0d cycles", name, wait_limit);
      end
      for (int p = 0; p < switch_pkg::num_ports; p++) begin
         checks++;
         assert (got_q[p].size() == exp_q[p].size()) else begin
            mismatches++;
            $display("mismatch %s port %0d word count expected %0d actual %0d",
                     name, p, exp_q[p].size(), got_q[p].size());
         end
         n = (got_q[p].size() < exp_q[p].size()) ? got_q[p].size() : exp_q[p].size();
         for (int i = 0; i < n; i++) begin
            checks++;
            assert (got_q[p][i] == exp_q[p][i]) else begin
               mismatches++;
               $display("mismatch %s port %0d word %0d expected %h actual %h",
                        name, p, i, exp_q[p][i], got_q[p][i]);
            end
         end
         got_q[p].delete();
         exp_q[p].delete();
      end
   endtask

   task automatic print_counts();
      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------
   task automatic flood_unknown_dst();
      word_q_t pkt;
      pkt = make_packet(mac_far, mac_a);
      add_expected(4'b1110, pkt);
      send_packet(0, pkt);
      wait_and_check("flood");
   endtask

   task automatic forward_to_learned();
      word_q_t pkt;
      pkt = make_packet(mac_a, mac_b);
      add_expected(4'b0001, pkt);
      send_packet(2, pkt);
      wait_and_check("learned");
   endtask

   // Destination lives on the arrival port, so only the second packet leaves
   task automatic filter_same_port();
      word_q_t drop_pkt;
      word_q_t pkt;
      drop_pkt = make_packet(mac_a, mac_c);
      pkt      = make_packet(mac_far2, mac_a);
      add_expected(4'b1110, pkt);
      send_packet(0, drop_pkt);
      send_packet(0, pkt);
      wait_and_check("filter");
   endtask

   task automatic arbitrate_four_ports();
      word_q_t pk [switch_pkg::num_ports];
      pk[0] = make_packet(mac_b, mac_quad + 48'd0);
      pk[1] = make_packet(mac_a, mac_quad + 48'd1);
      pk[2] = make_packet(mac_far, mac_quad + 48'd2);
      pk[3] = make_packet(mac_b, mac_quad + 48'd3);
      // Last grant was port 0, so ports 1, 2, 3, 0 follow in turn
      add_expected(4'b0001, pk[1]);
      add_expected(4'b1011, pk[2]);
      add_expected(4'b0100, pk[3]);
      add_expected(4'b0100, pk[0]);
      fork
         send_packet(0, pk[0]);
         send_packet(1, pk[1]);
         send_packet(2, pk[2]);
         send_packet(3, pk[3]);
      join
      wait_and_check("arbitration");
   endtask

   task automatic stall_on_backpressure();
      word_q_t pkt;
      @(posedge clk);
      #2;
      out_rdy[3] = 1'b0;
      pkt = make_packet(mac_far, mac_a);
      add_expected(4'b1110, pkt);
      send_packet(0, pkt);
      repeat (30) @(posedge clk);
      for (int p = 0; p < switch_pkg::num_ports; p++) begin
         checks++;
         assert (got_q[p].size() == 0) else begin
            failures++;
            $display("backpressure: port %0d sent a word while port 3 was not ready", p);
         end
      end
      #2;
      out_rdy[3] = 1'b1;
      wait_and_check("backpressure");
   endtask

   // Nine new sources into eight entries push out the first of them
   task automatic replace_oldest_entry();
      word_q_t pkt;
      for (int i = 1; i <= 9; i++) begin
         pkt = make_packet(mac_far, mac_new + 48'(i));
         add_expected(4'b0111, pkt);
         send_packet(3, pkt);
      end
      wait_and_check("replacement learn");
      pkt = make_packet(mac_new + 48'd1, mac_probe);
      add_expected(4'b1101, pkt);
      send_packet(1, pkt);
      wait_and_check("replacement evicted");
      pkt = make_packet(mac_new + 48'd9, mac_probe);
      add_expected(4'b1000, pkt);
      send_packet(1, pkt);
      wait_and_check("replacement kept");
   endtask

   initial begin
      reset   = 1'b1;
      in_wr   = '0;
      out_rdy = '1;
      for (int p = 0; p < switch_pkg::num_ports; p++) begin
         in_data[p] = '0;
         in_ctrl[p] = '0;
      end
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;
      flood_unknown_dst();
      forward_to_learned();
      filter_same_port();
      arbitrate_four_ports();
      stall_on_backpressure();
      replace_oldest_entry();
      print_counts();
      if (mismatches == 0 && failures == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
      print_counts();
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- sim.f
switch_pkg.sv
input_arbiter.sv
packet_buffer.sv
mac_lookup.sv
egress_demux.sv
sdn_switch.sv
tb_sdn_switch.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the switch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_sdn_switch -o tb_sdn_switch
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sdn_switch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
